/* verilog/rv_pkg.sv */
package rv_pkg;

  // datapath widths
  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;
  localparam int OPCODE_W   = 7;

  // major opcodes kept by the core
  localparam logic [OPCODE_W-1:0] OP_LUI     = 7'b0110111;
  localparam logic [OPCODE_W-1:0] OP_REG_IMM = 7'b0010011;
  localparam logic [OPCODE_W-1:0] OP_REG_REG = 7'b0110011;
  localparam logic [OPCODE_W-1:0] OP_BRANCH  = 7'b1100011;
  localparam logic [OPCODE_W-1:0] OP_STORE   = 7'b0100011;
  localparam logic [OPCODE_W-1:0] OP_ENVIRON = 7'b1110011;

  // branch conditions
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  // alu funct3, shared by reg-imm and reg-reg
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_SLTU    = 3'b011;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SRL_SRA = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  // word store is the only store width
  localparam logic [2:0] F3_SW = 3'b010;

  // funct7 base and alternate (sub, sra, srai)
  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000;

  // alu_pass_b forwards operand b, used by lui
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS_B
  } alu_op_e;

  // one instruction word, seen through each encoding format
  typedef union packed {
    struct packed {
      logic [6:0]            funct7;
      logic [REG_ADDR_W-1:0] rs2;
      logic [REG_ADDR_W-1:0] rs1;
      logic [2:0]            funct3;
      logic [REG_ADDR_W-1:0] rd;
      logic [OPCODE_W-1:0]   opcode;
    } r;
    struct packed {
      logic [11:0]           imm;
      logic [REG_ADDR_W-1:0] rs1;
      logic [2:0]            funct3;
      logic [REG_ADDR_W-1:0] rd;
      logic [OPCODE_W-1:0]   opcode;
    } i;
    struct packed {
      logic [6:0]            imm_hi;
      logic [REG_ADDR_W-1:0] rs2;
      logic [REG_ADDR_W-1:0] rs1;
      logic [2:0]            funct3;
      logic [4:0]            imm_lo;
      logic [OPCODE_W-1:0]   opcode;
    } s;
    struct packed {
      logic                  imm_12;
      logic [5:0]            imm_10_5;
      logic [REG_ADDR_W-1:0] rs2;
      logic [REG_ADDR_W-1:0] rs1;
      logic [2:0]            funct3;
      logic [3:0]            imm_4_1;
      logic                  imm_11;
      logic [OPCODE_W-1:0]   opcode;
    } b;
    struct packed {
      logic [19:0]           imm;
      logic [REG_ADDR_W-1:0] rd;
      logic [OPCODE_W-1:0]   opcode;
    } u;
  } rv_insn_u;

endpackage

/* verilog/decode_if.sv */
`timescale 1ns/1ps

interface decode_if;

  // operation and operands
  rv_pkg::alu_op_e                alu_op;
  logic [rv_pkg::XLEN-1:0]        imm;
  logic                           use_imm;
  logic [rv_pkg::REG_ADDR_W-1:0]  rs1_addr;
  logic [rv_pkg::REG_ADDR_W-1:0]  rs2_addr;
  logic [rv_pkg::REG_ADDR_W-1:0]  rd_addr;

  // control flags, all clear for a no-op
  logic                           rd_we;
  logic                           is_branch;
  logic [2:0]                     branch_f3;
  logic                           is_store;
  logic                           is_halt;

  modport dec (
    output alu_op, imm, use_imm, rs1_addr, rs2_addr, rd_addr,
    output rd_we, is_branch, branch_f3, is_store, is_halt
  );

  modport exe (
    input alu_op, imm, use_imm, rs1_addr, rs2_addr, rd_addr,
    input rd_we, is_branch, branch_f3, is_store, is_halt
  );

endinterface

/* verilog/rv_regfile.sv */
`timescale 1ns/1ps

module rv_regfile (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          we_i,
  input  logic [rv_pkg::REG_ADDR_W-1:0] rd_addr_i,
  input  logic [rv_pkg::XLEN-1:0]       rd_data_i,
  input  logic [rv_pkg::REG_ADDR_W-1:0] rs1_addr_i,
  input  logic [rv_pkg::REG_ADDR_W-1:0] rs2_addr_i,
  output logic [rv_pkg::XLEN-1:0]       rs1_data_o,
  output logic [rv_pkg::XLEN-1:0]       rs2_data_o
);

  logic [rv_pkg::XLEN-1:0] regs [2**rv_pkg::REG_ADDR_W];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int r = 0; r < 2**rv_pkg::REG_ADDR_W; r++) begin
        regs[r] <= '0;
      end
    end else if (we_i && rd_addr_i != '0) begin
      // x0 never written, stays zero from reset
      regs[rd_addr_i] <= rd_data_i;
    end
  end

  // two async read ports
  assign rs1_data_o = regs[rs1_addr_i];
  assign rs2_data_o = regs[rs2_addr_i];

endmodule

/* verilog/rv_fetch.sv */
`timescale 1ns/1ps

module rv_fetch #(
  parameter logic [rv_pkg::XLEN-1:0] RESET_PC = '0
) (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    imem_ack_i,
  input  logic [rv_pkg::XLEN-1:0] imem_rdata_i,
  input  logic                    branch_taken_i,
  input  logic [rv_pkg::XLEN-1:0] branch_target_i,
  decode_if.exe                   dec_i,
  output logic                    imem_req_o,
  output logic [rv_pkg::XLEN-1:0] imem_addr_o,
  output rv_pkg::rv_insn_u        insn_o,
  output logic [rv_pkg::XLEN-1:0] pc_o,
  output logic                    exec_o,
  output logic                    halt_o
);

  // handshake phases
  localparam logic [1:0] S_REQ  = 2'd0;
  localparam logic [1:0] S_REL  = 2'd1;
  localparam logic [1:0] S_EXEC = 2'd2;
  localparam logic [1:0] S_HALT = 2'd3;

  logic [1:0]              state_q;
  logic                    req_q;
  logic [rv_pkg::XLEN-1:0] pc_q;
  rv_pkg::rv_insn_u        insn_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= S_REQ;
      req_q   <= 1'b0;
      pc_q    <= RESET_PC;
    end else begin
      case (state_q)
        S_REQ: begin
          // first request after reset
          if (!req_q) begin
            req_q <= 1'b1;
          end else if (imem_ack_i) begin
            req_q   <= 1'b0;
            state_q <= S_REL;
          end
        end
        S_REL: begin
          // memory drops ack, fetch is done
          if (!imem_ack_i) begin
            state_q <= S_EXEC;
          end
        end
        S_EXEC: begin
          pc_q <= branch_taken_i ? branch_target_i : pc_q + 4;
          if (dec_i.is_halt) begin
            state_q <= S_HALT;
          end else begin
            // next req right after the exec cycle
            req_q   <= 1'b1;
            state_q <= S_REQ;
          end
        end
        default: begin
          // halted until reset
          state_q <= S_HALT;
        end
      endcase
    end
  end

  // word captured while ack is high
  always_ff @(posedge clk) begin
    if (state_q == S_REQ && req_q && imem_ack_i) begin
      insn_q <= imem_rdata_i;
    end
  end

  assign imem_req_o  = req_q;
  // pc only moves in exec, so the address holds while req is up
  assign imem_addr_o = pc_q;
  assign insn_o      = insn_q;
  assign pc_o        = pc_q;
  assign exec_o      = (state_q == S_EXEC);
  assign halt_o      = (state_q == S_HALT);

endmodule

/* verilog/rv_decoder.sv */
`timescale 1ns/1ps

module rv_decoder (
  input  rv_pkg::rv_insn_u insn_i,
  decode_if.dec            dec_o
);

  logic            alt;
  logic            shift_ok;
  logic            rr_ok;
  rv_pkg::alu_op_e arith_op;

  // funct7 sits in the same bits for reg-imm shifts and reg-reg
  assign alt = (insn_i.r.funct7 == rv_pkg::F7_ALT);

  // slli needs base funct7, srli/srai base or alt
  assign shift_ok = (insn_i.i.funct3 == rv_pkg::F3_SLL) ? (insn_i.r.funct7 == rv_pkg::F7_BASE) :
                    (insn_i.i.funct3 == rv_pkg::F3_SRL_SRA) ?
                    (insn_i.r.funct7 == rv_pkg::F7_BASE || alt) : 1'b1;

  // reg-reg alt only for sub and sra, anything else (mul/div) is a no-op
  assign rr_ok = (insn_i.r.funct7 == rv_pkg::F7_BASE) ||
                 (alt && (insn_i.r.funct3 == rv_pkg::F3_ADD_SUB ||
                          insn_i.r.funct3 == rv_pkg::F3_SRL_SRA));

  // alu op from funct3, sub only exists in reg-reg
  always_comb begin
    case (insn_i.r.funct3)
      rv_pkg::F3_ADD_SUB: begin
        arith_op = (alt && insn_i.r.opcode == rv_pkg::OP_REG_REG) ? rv_pkg::ALU_SUB
                                                                    : rv_pkg::ALU_ADD;
      end
      rv_pkg::F3_SLL:     arith_op = rv_pkg::ALU_SLL;
      rv_pkg::F3_SLT:     arith_op = rv_pkg::ALU_SLT;
      rv_pkg::F3_SLTU:    arith_op = rv_pkg::ALU_SLTU;
      rv_pkg::F3_XOR:     arith_op = rv_pkg::ALU_XOR;
      rv_pkg::F3_SRL_SRA: arith_op = alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
      rv_pkg::F3_OR:      arith_op = rv_pkg::ALU_OR;
      default:            arith_op = rv_pkg::ALU_AND;
    endcase
  end

  // register fields never move between formats
  assign dec_o.rs1_addr  = insn_i.r.rs1;
  assign dec_o.rs2_addr  = insn_i.r.rs2;
  assign dec_o.rd_addr   = insn_i.r.rd;
  assign dec_o.branch_f3 = insn_i.b.funct3;

  always_comb begin
    // unknown opcodes fall through as no-ops
    dec_o.alu_op    = rv_pkg::ALU_ADD;
    dec_o.imm       = '0;
    dec_o.use_imm   = 1'b0;
    dec_o.rd_we     = 1'b0;
    dec_o.is_branch = 1'b0;
    dec_o.is_store  = 1'b0;
    dec_o.is_halt   = 1'b0;
    case (insn_i.r.opcode)
      rv_pkg::OP_LUI: begin
        dec_o.alu_op  = rv_pkg::ALU_PASS_B;
        dec_o.imm     = {insn_i.u.imm, 12'b0};
        dec_o.use_imm = 1'b1;
        dec_o.rd_we   = 1'b1;
      end
      rv_pkg::OP_REG_IMM: begin
        // shamt is the low five bits of the i immediate
        dec_o.alu_op  = arith_op;
        dec_o.imm     = {{20{insn_i.i.imm[11]}}, insn_i.i.imm};
        dec_o.use_imm = 1'b1;
        dec_o.rd_we   = shift_ok;
      end
      rv_pkg::OP_REG_REG: begin
        dec_o.alu_op = arith_op;
        dec_o.rd_we  = rr_ok;
      end
      rv_pkg::OP_BRANCH: begin
        dec_o.imm = {{20{insn_i.b.imm_12}}, insn_i.b.imm_11, insn_i.b.imm_10_5,
                     insn_i.b.imm_4_1, 1'b0};
        dec_o.is_branch = insn_i.b.funct3 inside {rv_pkg::F3_BEQ, rv_pkg::F3_BNE,
                                                  rv_pkg::F3_BLT, rv_pkg::F3_BGE,
                                                  rv_pkg::F3_BLTU, rv_pkg::F3_BGEU};
      end
      rv_pkg::OP_STORE: begin
        // address = rs1 + s immediate through the adder
        dec_o.imm      = {{20{insn_i.s.imm_hi[6]}}, insn_i.s.imm_hi, insn_i.s.imm_lo};
        dec_o.use_imm  = 1'b1;
        dec_o.is_store = (insn_i.s.funct3 == rv_pkg::F3_SW);
      end
      rv_pkg::OP_ENVIRON: begin
        // ecall only, ebreak and csr ops are no-ops
        dec_o.is_halt = (insn_i.i.imm == 12'd0) && (insn_i.i.rs1 == '0) &&
                        (insn_i.i.funct3 == 3'd0) && (insn_i.i.rd == '0);
      end
      default: begin
        dec_o.use_imm = 1'b0;
      end
    endcase
  end

endmodule

/* verilog/rv_execute.sv */
`timescale 1ns/1ps

module rv_execute (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    exec_i,
  input  logic [rv_pkg::XLEN-1:0] pc_i,
  decode_if.exe                   dec_i,
  output logic                    branch_taken_o,
  output logic [rv_pkg::XLEN-1:0] branch_target_o,
  output logic                    dmem_we_o,
  output logic [rv_pkg::XLEN-1:0] dmem_addr_o,
  output logic [rv_pkg::XLEN-1:0] dmem_wdata_o
);

  logic [rv_pkg::XLEN-1:0] rs1_data;
  logic [rv_pkg::XLEN-1:0] rs2_data;
  logic [rv_pkg::XLEN-1:0] op_b;
  logic [rv_pkg::XLEN-1:0] alu_res;
  logic                    cond;
  logic                    we_q;

  // write-back lands on the edge that ends exec
  rv_regfile u_regfile (
    .clk        (clk),
    .rst        (rst),
    .we_i       (exec_i && dec_i.rd_we),
    .rd_addr_i  (dec_i.rd_addr),
    .rd_data_i  (alu_res),
    .rs1_addr_i (dec_i.rs1_addr),
    .rs2_addr_i (dec_i.rs2_addr),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data)
  );

  assign op_b = dec_i.use_imm ? dec_i.imm : rs2_data;

  // alu, shift amount from low five bits of b
  always_comb begin
    case (dec_i.alu_op)
      rv_pkg::ALU_ADD:  alu_res = rs1_data + op_b;
      rv_pkg::ALU_SUB:  alu_res = rs1_data - op_b;
      rv_pkg::ALU_SLL:  alu_res = rs1_data << op_b[4:0];
      rv_pkg::ALU_SLT:  alu_res = {31'b0, $signed(rs1_data) < $signed(op_b)};
      rv_pkg::ALU_SLTU: alu_res = {31'b0, rs1_data < op_b};
      rv_pkg::ALU_XOR:  alu_res = rs1_data ^ op_b;
      rv_pkg::ALU_SRL:  alu_res = rs1_data >> op_b[4:0];
      rv_pkg::ALU_SRA:  alu_res = $unsigned($signed(rs1_data) >>> op_b[4:0]);
      rv_pkg::ALU_OR:   alu_res = rs1_data | op_b;
      rv_pkg::ALU_AND:  alu_res = rs1_data & op_b;
      default:          alu_res = op_b;
    endcase
  end

  // branch compare always on rs1 vs rs2
  always_comb begin
    case (dec_i.branch_f3)
      rv_pkg::F3_BEQ:  cond = (rs1_data == rs2_data);
      rv_pkg::F3_BNE:  cond = (rs1_data != rs2_data);
      rv_pkg::F3_BLT:  cond = ($signed(rs1_data) < $signed(rs2_data));
      rv_pkg::F3_BGE:  cond = ($signed(rs1_data) >= $signed(rs2_data));
      rv_pkg::F3_BLTU: cond = (rs1_data < rs2_data);
      rv_pkg::F3_BGEU: cond = (rs1_data >= rs2_data);
      default:         cond = 1'b0;
    endcase
  end

  assign branch_taken_o  = dec_i.is_branch && cond;
  assign branch_target_o = pc_i + dec_i.imm;

  // store strobe, one cycle per sw
  always_ff @(posedge clk) begin
    if (rst) begin
      we_q <= 1'b0;
    end else begin
      we_q <= exec_i && dec_i.is_store;
    end
  end

  // address and data held from the last store
  always_ff @(posedge clk) begin
    if (exec_i && dec_i.is_store) begin
      dmem_addr_o  <= alu_res;
      dmem_wdata_o <= rs2_data;
    end
  end

  assign dmem_we_o = we_q;

endmodule

/* verilog/rv_core.sv */
`timescale 1ns/1ps

module rv_core #(
  parameter logic [rv_pkg::XLEN-1:0] RESET_PC = '0
) (
  input  logic                    clk,
  input  logic                    rst,
  output logic                    imem_req_o,
  output logic [rv_pkg::XLEN-1:0] imem_addr_o,
  input  logic                    imem_ack_i,
  input  logic [rv_pkg::XLEN-1:0] imem_rdata_i,
  output logic                    dmem_we_o,
  output logic [rv_pkg::XLEN-1:0] dmem_addr_o,
  output logic [rv_pkg::XLEN-1:0] dmem_wdata_o,
  output logic                    halt_o
);

  rv_pkg::rv_insn_u        insn;
  logic [rv_pkg::XLEN-1:0] pc;
  logic                    exec;
  logic                    branch_taken;
  logic [rv_pkg::XLEN-1:0] branch_target;

  // decoded control, decoder to execute and fetch
  decode_if dec_bus ();

  rv_fetch #(
    .RESET_PC (RESET_PC)
  ) u_fetch (
    .clk             (clk),
    .rst             (rst),
    .imem_ack_i      (imem_ack_i),
    .imem_rdata_i    (imem_rdata_i),
    .branch_taken_i  (branch_taken),
    .branch_target_i (branch_target),
    .dec_i           (dec_bus.exe),
    .imem_req_o      (imem_req_o),
    .imem_addr_o     (imem_addr_o),
    .insn_o          (insn),
    .pc_o            (pc),
    .exec_o          (exec),
    .halt_o          (halt_o)
  );

  rv_decoder u_decoder (
    .insn_i (insn),
    .dec_o  (dec_bus.dec)
  );

  rv_execute u_execute (
    .clk             (clk),
    .rst             (rst),
    .exec_i          (exec),
    .pc_i            (pc),
    .dec_i           (dec_bus.exe),
    .branch_taken_o  (branch_taken),
    .branch_target_o (branch_target),
    .dmem_we_o       (dmem_we_o),
    .dmem_addr_o     (dmem_addr_o),
    .dmem_wdata_o    (dmem_wdata_o)
  );

endmodule

/* verif/rv_core_properties.sv */
`timescale 1ns/1ps

module rv_core_properties (
  input logic                    clk,
  input logic                    rst,
  input logic                    req_i,
  input logic                    ack_i,
  input logic [rv_pkg::XLEN-1:0] addr_i,
  input logic                    we_i,
  input logic                    halt_i,
  input rv_pkg::rv_insn_u        insn_i
);

  // raised by any failing property
  logic violation = 1'b0;

  // address held for the whole request
  addr_stable: assert property (@(posedge clk) disable iff (rst)
    req_i |=> (!req_i || $stable(addr_i)))
    else begin
      violation = 1'b1;
      $error("fetch address changed while req was high");
    end

  // req drops only once ack has been seen
  req_fall: assert property (@(posedge clk) disable iff (rst)
    $fell(req_i) |-> $past(ack_i))
    else begin
      violation = 1'b1;
      $error("req dropped without ack");
    end

  // four-phase, ack must be low before a new req
  req_rise: assert property (@(posedge clk) disable iff (rst)
    $rose(req_i) |-> !$past(ack_i))
    else begin
      violation = 1'b1;
      $error("req raised while ack was still high");
    end

  // single-cycle store strobe
  we_pulse: assert property (@(posedge clk) disable iff (rst)
    we_i |=> !we_i)
    else begin
      violation = 1'b1;
      $error("store strobe high two cycles in a row");
    end

  // strobe only behind a store word
  we_store: assert property (@(posedge clk) disable iff (rst)
    we_i |-> insn_i.s.opcode == rv_pkg::OP_STORE)
    else begin
      violation = 1'b1;
      $error("store strobe without a store instruction");
    end

  // halt is sticky and silences fetch
  halt_hold: assert property (@(posedge clk) disable iff (rst)
    halt_i |=> (halt_i && !req_i))
    else begin
      violation = 1'b1;
      $error("halt dropped or fetch resumed after halt");
    end

endmodule

bind rv_core rv_core_properties u_props (
  .clk    (clk),
  .rst    (rst),
  .req_i  (imem_req_o),
  .ack_i  (imem_ack_i),
  .addr_i (imem_addr_o),
  .we_i   (dmem_we_o),
  .halt_i (halt_o),
  .insn_i (insn)
);

/* verif/rv_core_tb.sv */
`timescale 1ns/1ps

module rv_core_tb;

  localparam int WAIT_LIMIT  = 100;
  localparam int FETCH_LIMIT = 400;
  localparam int HALT_WINDOW = 40;

  // reg-reg ops on x2 = -5, x3 = 7
  localparam logic [6:0]  R_F7  [10] = '{7'h00, 7'h20, 7'h00, 7'h00, 7'h00,
                                         7'h00, 7'h00, 7'h20, 7'h00, 7'h00};
  localparam logic [2:0]  R_F3  [10] = '{3'd0, 3'd0, 3'd1, 3'd2, 3'd3,
                                         3'd4, 3'd5, 3'd5, 3'd6, 3'd7};
  localparam logic [31:0] R_RES [10] = '{32'h0000_0002, 32'hffff_fff4, 32'hffff_fd80,
                                         32'h0000_0001, 32'h0000_0000, 32'hffff_fffc,
                                         32'h01ff_ffff, 32'hffff_ffff, 32'hffff_ffff,
                                         32'h0000_0003};
  // reg-imm ops on x2, srai carries funct7 in the immediate
  localparam logic [2:0]  I_F3  [9]  = '{3'd0, 3'd2, 3'd3, 3'd4, 3'd6,
                                         3'd7, 3'd1, 3'd5, 3'd5};
  localparam logic [11:0] I_IMM [9]  = '{12'h123, 12'hffc, 12'hfff, 12'h0f0, 12'h004,
                                         12'h7f0, 12'h004, 12'h004, 12'h404};
  localparam logic [31:0] I_RES [9]  = '{32'h0000_011e, 32'h0000_0001, 32'h0000_0001,
                                         32'hffff_ff0b, 32'hffff_ffff, 32'h0000_07f0,
                                         32'hffff_ffb0, 32'h0fff_ffff, 32'hffff_ffff};
  // branches, even entries taken, odd entries fall through
  localparam logic [2:0]  B_F3  [6]  = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
  localparam logic [4:0]  B_RS1 [12] = '{5'd3, 5'd2, 5'd2, 5'd3, 5'd2, 5'd3,
                                         5'd3, 5'd2, 5'd3, 5'd2, 5'd2, 5'd3};
  localparam logic [4:0]  B_RS2 [12] = '{5'd3, 5'd3, 5'd3, 5'd3, 5'd3, 5'd2,
                                         5'd2, 5'd3, 5'd2, 5'd3, 5'd3, 5'd2};

  logic        clk;
  logic        rst;
  logic        imem_req;
  logic [31:0] imem_addr;
  logic        imem_ack;
  logic [31:0] imem_rdata;
  logic        dmem_we;
  logic [31:0] dmem_addr;
  logic [31:0] dmem_wdata;
  logic        halt;

  logic [31:0] prog [$];
  logic [31:0] exp_pc [$];
  logic [31:0] exp_addr [$];
  logic [31:0] exp_data [$];
  int          seen = 0;
  int          fetch_no = 0;
  int          slot = 0;
  int          seed;
  int          wait_cnt;

  rv_core #(
    .RESET_PC (32'h0)
  ) uut (
    .clk          (clk),
    .rst          (rst),
    .imem_req_o   (imem_req),
    .imem_addr_o  (imem_addr),
    .imem_ack_i   (imem_ack),
    .imem_rdata_i (imem_rdata),
    .dmem_we_o    (dmem_we),
    .dmem_addr_o  (dmem_addr),
    .dmem_wdata_o (dmem_wdata),
    .halt_o       (halt)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic value_error(input string msg);
    $display("[ERROR] %0t %s", $time, msg);
    $display("sim failed");
    $fatal(1);
  endtask

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("sim failed");
    $fatal(1);
  endtask

  // instruction encoders, straight from the isa formats
  function automatic logic [31:0] rtype(input logic [6:0] f7, input logic [2:0] f3,
                                        input logic [4:0] rd, input logic [4:0] rs1,
                                        input logic [4:0] rs2);
    rtype = {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] itype(input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [4:0] rs1, input logic [11:0] imm);
    itype = {imm, rs1, f3, rd, 7'b0010011};
  endfunction

  function automatic logic [31:0] stype(input logic [4:0] rs2, input logic [4:0] rs1,
                                        input logic [11:0] imm);
    stype = {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] btype(input logic [2:0] f3, input logic [4:0] rs1,
                                        input logic [4:0] rs2, input logic [12:0] imm);
    btype = {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  // word on the fetch path, its address is the next expected fetch
  task automatic put(input logic [31:0] word);
    exp_pc.push_back(32'(prog.size() * 4));
    prog.push_back(word);
  endtask

  task automatic note_store(input logic [31:0] addr, input logic [31:0] data);
    exp_addr.push_back(addr);
    exp_data.push_back(data);
  endtask

  // sw rs2 to the next free word off x0, on the path and in the table if it must happen
  task automatic store_slot(input logic [4:0] rs2, input logic [31:0] data, input bit keep);
    logic [11:0] offs;
    offs = 12'(slot * 4);
    if (keep) begin
      put(stype(rs2, 5'd0, offs));
      note_store({20'd0, offs}, data);
    end else begin
      // jumped over by the taken branch before it, never fetched
      prog.push_back(stype(rs2, 5'd0, offs));
    end
    slot++;
  endtask

  task automatic build_program();
    // lui x1, addi x2 = -5, addi x3 = 7
    put({20'h80000, 5'd1, 7'b0110111});
    put(itype(3'd0, 5'd2, 5'd0, 12'hffb));
    put(itype(3'd0, 5'd3, 5'd0, 12'h007));
    store_slot(5'd1, 32'h8000_0000, 1'b1);
    for (int k = 0; k < 10; k++) begin
      put(rtype(R_F7[k], R_F3[k], 5'd4, 5'd2, 5'd3));
      store_slot(5'd4, R_RES[k], 1'b1);
    end
    for (int k = 0; k < 9; k++) begin
      put(itype(I_F3[k], 5'd4, 5'd2, I_IMM[k]));
      store_slot(5'd4, I_RES[k], 1'b1);
    end
    // write to x0 is dropped
    put(itype(3'd0, 5'd0, 5'd3, 12'h005));
    store_slot(5'd0, 32'h0, 1'b1);
    // store with a nonzero base, sw x2, 16(x1)
    put(stype(5'd2, 5'd1, 12'h010));
    note_store(32'h8000_0010, 32'hffff_fffb);
    // taken branch skips its store, +8 lands past it
    for (int b = 0; b < 12; b++) begin
      put(btype(B_F3[b / 2], B_RS1[b], B_RS2[b], 13'd8));
      store_slot(5'd3, 32'd7, b % 2 == 1);
    end
    put(32'h0000_0073);
  endtask

  // req or halt, sampled on the falling edge
  task automatic wait_request();
    wait_cnt = 0;
    while (!imem_req && !halt) begin
      @(negedge clk);
      wait_cnt++;
      if (wait_cnt > WAIT_LIMIT) begin
        abort_run("timed out waiting for an instruction request");
      end
    end
  endtask

  // memory side of one four-phase transfer
  task automatic serve_fetch();
    int delay;
    int idx;
    wait_request();
    if (imem_req) begin
      // each fetch follows the path, branches included
      assert (fetch_no < exp_pc.size())
        else value_error($sformatf("fetch from %h beyond the expected path", imem_addr));
      assert (imem_addr == exp_pc[fetch_no])
        else value_error($sformatf("fetch %0d from %h, expected %h", fetch_no, imem_addr,
                                   exp_pc[fetch_no]));
      idx = int'(imem_addr >> 2);
      fetch_no++;
      delay = $unsigned($random(seed)) % 4;
      repeat (delay) @(negedge clk);
      imem_ack   = 1'b1;
      imem_rdata = prog[idx];
      wait_cnt   = 0;
      while (imem_req) begin
        @(negedge clk);
        wait_cnt++;
        if (wait_cnt > WAIT_LIMIT) begin
          abort_run("timed out waiting for req to drop after ack");
        end
      end
      imem_ack = 1'b0;
    end
  endtask

  // stores compared in order against the table
  always @(negedge clk) begin
    if (!rst) begin
      assert (!uut.u_props.violation)
        else abort_run("a handshake or control property failed");
      if (dmem_we) begin
        assert (seen < exp_addr.size())
          else value_error($sformatf("unexpected store to %h", dmem_addr));
        assert (dmem_addr == exp_addr[seen] && dmem_wdata == exp_data[seen])
          else value_error($sformatf("store %0d wrote %h to %h, expected %h to %h", seen,
                                     dmem_wdata, dmem_addr, exp_data[seen], exp_addr[seen]));
        seen++;
      end
    end
  end

  initial begin
    int fetches;
    seed       = 32'hf059_4100;
    rst        = 1'b1;
    imem_ack   = 1'b0;
    imem_rdata = '0;
    build_program();
    repeat (5) @(negedge clk);
    assert (!imem_req && !dmem_we && !halt)
      else value_error("outputs not idle during reset");
    rst = 1'b0;
    // first request from the reset pc
    wait_request();
    assert (imem_req && imem_addr == 32'h0)
      else value_error($sformatf("first fetch from %h, expected 0", imem_addr));
    fetches = 0;
    while (!halt) begin
      serve_fetch();
      fetches++;
      if (fetches > FETCH_LIMIT) begin
        abort_run("too many fetches, the program never reached ecall");
      end
    end
    // quiet window after ecall
    wait_cnt = 0;
    while (wait_cnt < HALT_WINDOW) begin
      @(negedge clk);
      assert (halt && !imem_req)
        else value_error("halt dropped or req raised after halt");
      wait_cnt++;
    end
    if (seen == exp_addr.size()) begin
      $display("sim passed");
      $finish;
    end else begin
      value_error($sformatf("only %0d of %0d stores seen at halt", seen, exp_addr.size()));
    end
  end

endmodule

/* rv_core.f */
verilog/rv_pkg.sv
verilog/decode_if.sv
verilog/rv_regfile.sv
verilog/rv_fetch.sv
verilog/rv_decoder.sv
verilog/rv_execute.sv
verilog/rv_core.sv
verif/rv_core_properties.sv
verif/rv_core_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build with verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" \
  && verilator --binary --timing --assert -Wno-fatal --top-module rv_core_tb -f rv_core.f \
  && ./obj_dir/Vrv_core_tb +verilator+error+limit+10 | tee /dev/stderr | grep -q "sim passed" \
  && echo "run ok" \
  || { echo "run did not pass"; exit 1; }
